/* src/mesiPkg.sv */
package mesiPkg;

	typedef logic [15:0] addrT; // Word address
	typedef logic [31:0] dataT;

	// Line state in a private cache
	typedef enum logic [1:0] {
		Invalid,
		Shared,
		Exclusive,
		Modified
	} mesiStateT;

	// Commands placed on the snooping bus
	typedef enum logic [2:0] {
		BusIdle,
		BusRd,
		BusRdX,
		BusUpgr,
		BusWb
	} busCmdT;

endpackage

/* src/busArbiter.sv */
`timescale 1ns/1ns

module busArbiter #(
	parameter int numDevices = 2
) (
	input  logic clock,
	input  logic rstN,
	input  logic [numDevices-1:0] busReq,
	output logic [numDevices-1:0] busGrant
);

	localparam int ptrWidth = numDevices > 1 ? $clog2(numDevices) : 1;

	logic [ptrWidth-1:0] lastOwner;
	logic [ptrWidth-1:0] nextOwner;
	logic [numDevices-1:0] nextGrant;

	// First requester after the last owner wins
	always_comb begin
		int cand;
		nextGrant = '0;
		nextOwner = lastOwner;
		for (int k = numDevices; k >= 1; k--) begin
			cand = (int'(lastOwner) + k) % numDevices;
			if (busReq[cand]) begin
				nextGrant = '0;
				nextGrant[cand] = 1'b1;
				nextOwner = ptrWidth'(cand);
			end
		end
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			busGrant <= '0;
			lastOwner <= ptrWidth'(numDevices - 1);
		end else if (busGrant == '0) begin
			busGrant <= nextGrant;
			lastOwner <= nextOwner;
		end else if ((busGrant & busReq) == '0) begin
			busGrant <= '0; // Owner let go
		end
	end

endmodule

/* src/mainMemory.sv */
`timescale 1ns/1ns

module mainMemory #(
	parameter int memLatency = 4
) (
	input  logic clock,
	input  logic rstN,
	input  logic memValid,
	input  logic memWrite,
	input  mesiPkg::addrT memAddr,
	input  mesiPkg::dataT memWData,
	output logic memDone,
	output mesiPkg::dataT memRData
);
	import mesiPkg::*;

	localparam int cntWidth = $clog2(memLatency + 1);

	dataT mem [1 << $bits(addrT)] = '{default: '0};

	logic busy;
	logic [cntWidth-1:0] count;
	logic writeQ;
	addrT addrQ;
	dataT wDataQ;

	assign memDone = busy && count == cntWidth'(1);
	assign memRData = mem[addrQ];

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			count <= '0;
		end else if (memValid && !busy) begin
			busy <= 1'b1;
			count <= cntWidth'(memLatency);
		end else if (busy) begin
			if (memDone)
				busy <= 1'b0;
			else
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (memValid && !busy) begin
			writeQ <= memWrite;
			addrQ <= memAddr;
			wDataQ <= memWData;
		end
		if (memDone && writeQ)
			mem[addrQ] <= wDataQ; // Commit at end of access
	end

endmodule

/* src/snoopBus.sv */
`timescale 1ns/1ns

module snoopBus #(
	parameter int numDevices = 2
) (
	input  logic clock,
	input  logic rstN,
	input  logic [numDevices-1:0] busReq,
	input  mesiPkg::busCmdT busCmd [numDevices],
	input  mesiPkg::addrT busAddr [numDevices],
	input  mesiPkg::dataT busWData [numDevices],
	input  logic [numDevices-1:0] busGrant,
	output logic [numDevices-1:0] busDone,
	output mesiPkg::dataT busRData,
	output logic busShared,
	output logic snoopValid,
	output logic [numDevices-1:0] snoopSrc,
	output mesiPkg::busCmdT snoopCmd,
	output mesiPkg::addrT snoopAddr,
	input  logic [numDevices-1:0] snoopShared,
	input  logic [numDevices-1:0] snoopFlush,
	input  mesiPkg::dataT snoopData [numDevices],
	output logic memValid,
	output logic memWrite,
	output mesiPkg::addrT memAddr,
	output mesiPkg::dataT memWData,
	input  logic memDone,
	input  mesiPkg::dataT memRData
);
	import mesiPkg::*;

	typedef enum logic [2:0] {Idle, Snoop, Collect, MemAccess, Done} busStateT;

	busStateT state;
	logic [numDevices-1:0] ownerQ;
	logic [numDevices-1:0] active;
	logic [numDevices-1:0] flushers;
	busCmdT cmdQ;
	busCmdT selCmd;
	addrT addrQ;
	addrT selAddr;
	dataT wDataQ;
	dataT selWData;
	dataT flushData;
	dataT rDataQ;
	logic sharedQ;

	assign active = busGrant & busReq;
	assign flushers = snoopFlush & ~ownerQ;

	always_comb begin
		selCmd = BusIdle;
		selAddr = '0;
		selWData = '0;
		flushData = '0;
		for (int k = 0; k < numDevices; k++) begin
			if (active[k]) begin
				selCmd = busCmd[k];
				selAddr = busAddr[k];
				selWData = busWData[k];
			end
			if (flushers[k])
				flushData = snoopData[k]; // Only one Modified owner
		end
	end

	assign snoopValid = state == Snoop;
	assign snoopSrc = ownerQ;
	assign snoopCmd = snoopValid ? cmdQ : BusIdle;
	assign snoopAddr = addrQ;
	assign busDone = state == Done ? ownerQ : '0;
	assign busRData = rDataQ;
	assign busShared = sharedQ;
	assign memAddr = addrQ;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= Idle;
			ownerQ <= '0;
			cmdQ <= BusIdle;
			sharedQ <= 1'b0;
			memValid <= 1'b0;
			memWrite <= 1'b0;
		end else begin
			case (state)
				Idle: begin
					if (active != '0) begin
						ownerQ <= active;
						cmdQ <= selCmd;
						state <= Snoop;
					end
				end
				Snoop: state <= Collect;
				Collect: begin
					sharedQ <= (snoopShared & ~ownerQ) != '0;
					if (cmdQ == BusUpgr) begin
						state <= Done; // Invalidation only
					end else begin
						memValid <= 1'b1;
						memWrite <= cmdQ == BusWb || flushers != '0;
						state <= MemAccess;
					end
				end
				MemAccess: begin
					memValid <= 1'b0;
					if (memDone)
						state <= Done;
				end
				Done: state <= Idle;
				default: state <= Idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == Idle && active != '0) begin
			addrQ <= selAddr;
			wDataQ <= selWData;
		end
		if (state == Collect) begin
			memWData <= cmdQ == BusWb ? wDataQ : flushData;
			rDataQ <= flushData;
		end
		if (state == MemAccess && memDone && !memWrite)
			rDataQ <= memRData;
	end

endmodule

/* src/mesiCacheController.sv */
`timescale 1ns/1ns

module mesiCacheController #(
	parameter int indexWidth = 3
) (
	input  logic clock,
	input  logic rstN,
	input  logic reqValid,
	output logic reqReady,
	input  logic reqWrite,
	input  mesiPkg::addrT reqAddr,
	input  mesiPkg::dataT reqData,
	output logic respValid,
	input  logic respReady,
	output mesiPkg::dataT respData,
	output logic busReq,
	output mesiPkg::busCmdT busCmd,
	output mesiPkg::addrT busAddr,
	output mesiPkg::dataT busWData,
	input  logic busGrant,
	input  logic busDone,
	input  mesiPkg::dataT busRData,
	input  logic busShared,
	input  logic snoopValid,
	input  logic snoopSelf,
	input  mesiPkg::busCmdT snoopCmd,
	input  mesiPkg::addrT snoopAddr,
	output logic snoopShared,
	output logic snoopFlush,
	output mesiPkg::dataT snoopData
);
	import mesiPkg::*;

	localparam int numLines = 1 << indexWidth;
	localparam int tagWidth = $bits(addrT) - indexWidth;

	typedef logic [indexWidth-1:0] indexT;
	typedef logic [tagWidth-1:0] tagT;
	typedef enum logic [2:0] {Idle, Lookup, Writeback, Miss, Respond} ctrlStateT;

	ctrlStateT state;

	tagT tagArr [numLines];
	dataT dataArr [numLines];
	mesiStateT lineState [numLines];

	logic writeQ;
	addrT addrQ;
	dataT wDataQ;
	dataT respDataQ;

	indexT idx;
	tagT tag;
	indexT sIdx;
	tagT sTag;
	logic lineValid;
	logic snoopOther;
	logic snoopConflict;
	logic snoopHit;
	logic hit;
	logic busFinish;
	logic accept;
	dataT hitData;

	assign idx = addrQ[indexWidth-1:0];
	assign tag = addrQ[$bits(addrT)-1:indexWidth];
	assign sIdx = snoopAddr[indexWidth-1:0];
	assign sTag = snoopAddr[$bits(addrT)-1:indexWidth];

	assign accept = state == Idle && reqValid && reqReady;
	assign lineValid = lineState[idx] != Invalid && tagArr[idx] == tag;
	assign snoopOther = snoopValid && !snoopSelf;
	assign snoopConflict = snoopOther && sIdx == idx; // Snoop side owns the line this cycle
	assign snoopHit = snoopOther && lineState[sIdx] != Invalid && tagArr[sIdx] == sTag;
	assign hit = lineValid && !snoopConflict
		&& (!writeQ || lineState[idx] == Exclusive || lineState[idx] == Modified);
	assign busFinish = busGrant && busDone;
	assign hitData = writeQ ? wDataQ : dataArr[idx];

	assign respValid = state == Respond || (state == Lookup && hit);
	assign respData = state == Respond ? respDataQ : hitData;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= Idle;
			reqReady <= 1'b0;
			busReq <= 1'b0;
			busCmd <= BusIdle;
			snoopShared <= 1'b0;
			snoopFlush <= 1'b0;
			for (int i = 0; i < numLines; i++)
				lineState[i] <= Invalid;
		end else begin
			snoopShared <= 1'b0;
			snoopFlush <= 1'b0;
			if (snoopHit) begin
				snoopShared <= snoopCmd != BusWb;
				snoopFlush <= lineState[sIdx] == Modified
					&& (snoopCmd == BusRd || snoopCmd == BusRdX);
				if (snoopCmd == BusRd)
					lineState[sIdx] <= Shared; // Downgrade
				else if (snoopCmd == BusRdX || snoopCmd == BusUpgr)
					lineState[sIdx] <= Invalid;
			end

			case (state)
				Idle: begin
					reqReady <= 1'b1;
					if (accept) begin
						reqReady <= 1'b0;
						state <= Lookup;
					end
				end
				Lookup: begin
					if (!snoopConflict) begin
						if (hit) begin
							if (writeQ)
								lineState[idx] <= Modified;
							if (respReady) begin
								reqReady <= 1'b1;
								state <= Idle;
							end else begin
								state <= Respond;
							end
						end else if (lineValid && writeQ) begin
							busReq <= 1'b1; // Write to a Shared copy
							busCmd <= BusUpgr;
							state <= Miss;
						end else if (lineState[idx] == Modified) begin
							busReq <= 1'b1; // Dirty victim goes first
							busCmd <= BusWb;
							state <= Writeback;
						end else begin
							busReq <= 1'b1;
							busCmd <= writeQ ? BusRdX : BusRd;
							state <= Miss;
						end
					end
				end
				Writeback: begin
					if (busFinish) begin
						busReq <= 1'b0;
						lineState[idx] <= Invalid;
						state <= Lookup; // Retry as a plain miss
					end
				end
				Miss: begin
					if (busFinish) begin
						busReq <= 1'b0;
						lineState[idx] <= writeQ ? Modified : (busShared ? Shared : Exclusive);
						state <= Respond;
					end
				end
				Respond: begin
					if (respReady) begin
						reqReady <= 1'b1;
						state <= Idle;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			writeQ <= reqWrite;
			addrQ <= reqAddr;
			wDataQ <= reqData;
		end
		if (state == Lookup && !snoopConflict) begin
			if (hit) begin
				respDataQ <= hitData;
				if (writeQ)
					dataArr[idx] <= wDataQ;
			end
			busAddr <= (lineState[idx] == Modified && !lineValid) ? {tagArr[idx], idx} : addrQ;
			busWData <= dataArr[idx];
		end
		if (state == Miss && busFinish) begin
			tagArr[idx] <= tag;
			dataArr[idx] <= writeQ ? wDataQ : busRData;
			respDataQ <= writeQ ? wDataQ : busRData;
		end
		snoopData <= dataArr[sIdx];
	end

endmodule

/* src/mesiCacheSystem.sv */
`timescale 1ns/1ns

module mesiCacheSystem #(
	parameter int numDevices = 2,
	parameter int indexWidth = 3,
	parameter int memLatency = 4
) (
	input  logic clock,
	input  logic rstN,
	input  logic [numDevices-1:0] reqValid,
	output logic [numDevices-1:0] reqReady,
	input  logic [numDevices-1:0] reqWrite,
	input  mesiPkg::addrT reqAddr [numDevices],
	input  mesiPkg::dataT reqData [numDevices],
	output logic [numDevices-1:0] respValid,
	input  logic [numDevices-1:0] respReady,
	output mesiPkg::dataT respData [numDevices]
);
	import mesiPkg::*;

	logic [numDevices-1:0] busReq;
	busCmdT busCmd [numDevices];
	addrT busAddr [numDevices];
	dataT busWData [numDevices];
	logic [numDevices-1:0] busGrant;
	logic [numDevices-1:0] busDone;
	dataT busRData;
	logic busShared;

	logic snoopValid;
	logic [numDevices-1:0] snoopSrc;
	busCmdT snoopCmd;
	addrT snoopAddr;
	logic [numDevices-1:0] snoopShared;
	logic [numDevices-1:0] snoopFlush;
	dataT snoopData [numDevices];

	logic memValid;
	logic memWrite;
	addrT memAddr;
	dataT memWData;
	logic memDone;
	dataT memRData;

	for (genvar g = 0; g < numDevices; g++) begin : genCache
		mesiCacheController #(
			.indexWidth(indexWidth)
		) i_cache (
			.clock(clock),
			.rstN(rstN),
			.reqValid(reqValid[g]),
			.reqReady(reqReady[g]),
			.reqWrite(reqWrite[g]),
			.reqAddr(reqAddr[g]),
			.reqData(reqData[g]),
			.respValid(respValid[g]),
			.respReady(respReady[g]),
			.respData(respData[g]),
			.busReq(busReq[g]),
			.busCmd(busCmd[g]),
			.busAddr(busAddr[g]),
			.busWData(busWData[g]),
			.busGrant(busGrant[g]),
			.busDone(busDone[g]),
			.busRData(busRData),
			.busShared(busShared),
			.snoopValid(snoopValid),
			.snoopSelf(snoopSrc[g]), // Ignore own broadcast
			.snoopCmd(snoopCmd),
			.snoopAddr(snoopAddr),
			.snoopShared(snoopShared[g]),
			.snoopFlush(snoopFlush[g]),
			.snoopData(snoopData[g])
		);
	end

	busArbiter #(
		.numDevices(numDevices)
	) i_arbiter (
		.clock(clock),
		.rstN(rstN),
		.busReq(busReq),
		.busGrant(busGrant)
	);

	snoopBus #(
		.numDevices(numDevices)
	) i_bus (
		.clock(clock),
		.rstN(rstN),
		.busReq(busReq),
		.busCmd(busCmd),
		.busAddr(busAddr),
		.busWData(busWData),
		.busGrant(busGrant),
		.busDone(busDone),
		.busRData(busRData),
		.busShared(busShared),
		.snoopValid(snoopValid),
		.snoopSrc(snoopSrc),
		.snoopCmd(snoopCmd),
		.snoopAddr(snoopAddr),
		.snoopShared(snoopShared),
		.snoopFlush(snoopFlush),
		.snoopData(snoopData),
		.memValid(memValid),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.memWData(memWData),
		.memDone(memDone),
		.memRData(memRData)
	);

	mainMemory #(
		.memLatency(memLatency)
	) i_mem (
		.clock(clock),
		.rstN(rstN),
		.memValid(memValid),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.memWData(memWData),
		.memDone(memDone),
		.memRData(memRData)
	);

endmodule

/* tests/clockGen.sv */
`timescale 1ns/1ns

module clockGen #(
	parameter int halfPeriod = 2,
	parameter int resetCycles = 10
) (
	output logic clock,
	output logic rstN
);

	initial begin
		clock = 1'b0;
		forever #halfPeriod clock = ~clock;
	end

	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clock);
		#1 rstN = 1'b1; // Released on the drive slot
	end

endmodule

/* tests/mesiSystem_props.sv */
`timescale 1ns/1ns

module mesiSystem_props #(
	parameter int numDevices = 2
) (
	input  logic clock,
	input  logic rstN,
	input  logic [numDevices-1:0] grant,
	input  logic [numDevices-1:0] shared,
	input  logic [numDevices-1:0] flush,
	input  logic [numDevices-1:0] src,
	input  logic respValid,
	input  logic respReady,
	input  mesiPkg::dataT respData
);

	int failCount = 0;

	assert property (@(posedge clock) disable iff (!rstN) $onehot0(grant))
		else begin
			$error("bus grant is not one-hot or zero");
			failCount++;
		end

	// A flushing owner held the line Modified, so nobody else may answer shared
	assert property (@(posedge clock) disable iff (!rstN)
		$onehot0(flush) && (flush == '0 || (shared & ~flush & ~src) == '0))
		else begin
			$error("Modified line coexists with another valid copy");
			failCount++;
		end

	assert property (@(posedge clock) disable iff (!rstN)
		respValid && !respReady |=> respValid && $stable(respData))
		else begin
			$error("response dropped or changed under back-pressure");
			failCount++;
		end

endmodule

bind snoopBus mesiSystem_props #(
	.numDevices(numDevices)
) i_props (
	.clock(clock),
	.rstN(rstN),
	.grant(busGrant),
	.shared(snoopShared),
	.flush(snoopFlush),
	.src(snoopSrc),
	.respValid(1'b0),
	.respReady(1'b1),
	.respData('0)
);

bind mesiCacheController mesiSystem_props #(
	.numDevices(1)
) i_props (
	.clock(clock),
	.rstN(rstN),
	.grant(busGrant),
	.shared(1'b0),
	.flush(1'b0),
	.src(1'b0),
	.respValid(respValid),
	.respReady(respReady),
	.respData(respData)
);

/* tests/mesiSystem_tb.sv */
`timescale 1ns/1ns

module mesiSystem_tb;
	import mesiPkg::*;

	localparam int numDevices = 2;
	localparam int timeoutCycles = 300;

	typedef struct packed {
		logic [1:0] dev;
		logic write;
		addrT addr;
		dataT data;
		dataT expRead;
		logic expHit;
		logic parallel; // Runs together with the next row
		logic backPressure;
	} stepT;

	logic clock;
	logic rstN;
	logic [numDevices-1:0] reqValid;
	logic [numDevices-1:0] reqReady;
	logic [numDevices-1:0] reqWrite;
	addrT reqAddr [numDevices];
	dataT reqData [numDevices];
	logic [numDevices-1:0] respValid;
	logic [numDevices-1:0] respReady;
	dataT respData [numDevices];

	stepT steps [$];
	integer seed;
	int cycleCount = 0;
	int propFailures;

	clockGen #(.halfPeriod(2), .resetCycles(10)) i_clock (.clock(clock), .rstN(rstN));

	mesiCacheSystem #(
		.numDevices(numDevices),
		.indexWidth(3),
		.memLatency(4)
	) i_dut (
		.clock(clock),
		.rstN(rstN),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.reqWrite(reqWrite),
		.reqAddr(reqAddr),
		.reqData(reqData),
		.respValid(respValid),
		.respReady(respReady),
		.respData(respData)
	);

	assign propFailures = i_dut.i_bus.i_props.failCount
		+ i_dut.genCache[0].i_cache.i_props.failCount
		+ i_dut.genCache[1].i_cache.i_props.failCount;

	always @(posedge clock)
		cycleCount <= cycleCount + 1;

	always @(negedge clock) begin
		if (propFailures != 0)
			abortRun("A bound assertion on the bus or a cache failed");
	end

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkData(input string name, input dataT actual, input dataT expected);
		if (actual !== expected)
			abortRun($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
				$time, name, actual, expected));
	endtask

	task automatic checkLatency(input string name, input int actual, input int expected);
		if (actual != expected)
			abortRun($sformatf("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
				$time, name, actual, expected));
	endtask

	function automatic void addStep(int dev, logic write, addrT addr, dataT data,
			dataT expRead, logic expHit, logic parallel, logic backPressure);
		stepT s;
		s.dev = 2'(dev);
		s.write = write;
		s.addr = addr;
		s.data = data;
		s.expRead = expRead;
		s.expHit = expHit;
		s.parallel = parallel;
		s.backPressure = backPressure;
		steps.push_back(s);
	endfunction

	function automatic int pickHold();
		return ($random(seed) & 3) + 1;
	endfunction

	// Starts and ends one cycle slot after a rising edge
	task automatic performAccess(input int dev, input logic write, input addrT addr,
			input dataT data, input int hold, output dataT rdata, output int latency);
		int waitCnt;
		int startCycle;
		reqValid[dev] = 1'b1;
		reqWrite[dev] = write;
		reqAddr[dev] = addr;
		reqData[dev] = data;
		respReady[dev] = hold == 0;
		waitCnt = 0;
		@(negedge clock);
		while (!reqReady[dev]) begin
			waitCnt++;
			if (waitCnt > timeoutCycles)
				abortRun($sformatf("Device %0d never accepted its request", dev));
			@(negedge clock);
		end
		startCycle = cycleCount;
		@(posedge clock);
		#1 reqValid[dev] = 1'b0;
		waitCnt = 0;
		@(negedge clock);
		while (!respValid[dev]) begin
			waitCnt++;
			if (waitCnt > timeoutCycles)
				abortRun($sformatf("Device %0d never answered address %h", dev, addr));
			@(negedge clock);
		end
		latency = cycleCount - startCycle;
		if (hold > 0) begin
			repeat (hold) @(posedge clock);
			#1 respReady[dev] = 1'b1;
			@(negedge clock);
		end
		waitCnt = 0;
		while (!(respValid[dev] && respReady[dev])) begin
			waitCnt++;
			if (waitCnt > timeoutCycles)
				abortRun($sformatf("Device %0d lost its response", dev));
			@(negedge clock);
		end
		rdata = respData[dev];
		@(posedge clock);
		#1 respReady[dev] = 1'b1;
	endtask

	task automatic runStep(input int idx, input int hold);
		stepT s;
		dataT got;
		int latency;
		s = steps[idx];
		performAccess(s.dev, s.write, s.addr, s.data, hold, got, latency);
		checkData($sformatf("respData[%0d]", s.dev), got, s.expRead);
		if (s.expHit)
			checkLatency($sformatf("hit latency of device %0d", s.dev), latency, 1);
		else if (latency <= 1)
			abortRun($sformatf("Miss by device %0d at %h came back like a hit", s.dev, s.addr));
	endtask

	initial begin
		int i;
		int waitCnt;
		int holdA;
		int holdB;
		seed = 32'he8f829de;
		reqValid = '0;
		reqWrite = '0;
		respReady = '1;
		for (int d = 0; d < numDevices; d++) begin
			reqAddr[d] = '0;
			reqData[d] = '0;
		end

		// dev write addr data expRead hit parallel backPressure
		addStep(0, 0, 16'h0010, 32'h0, 32'h0, 0, 0, 0); // Never-written memory
		addStep(0, 0, 16'h0010, 32'h0, 32'h0, 1, 0, 0);
		addStep(0, 1, 16'h0021, 32'hA5A50001, 32'hA5A50001, 0, 0, 1);
		addStep(1, 0, 16'h0021, 32'h0, 32'hA5A50001, 0, 0, 0); // Flush from owner
		addStep(1, 0, 16'h0021, 32'h0, 32'hA5A50001, 1, 0, 0);
		addStep(1, 0, 16'h0032, 32'h0, 32'h0, 0, 0, 0);
		addStep(0, 0, 16'h0032, 32'h0, 32'h0, 0, 0, 1);
		addStep(0, 1, 16'h0032, 32'h12345678, 32'h12345678, 0, 0, 0); // Upgrade
		addStep(1, 0, 16'h0032, 32'h0, 32'h12345678, 0, 0, 1);
		addStep(0, 0, 16'h0032, 32'h0, 32'h12345678, 1, 0, 0);
		addStep(0, 1, 16'h0043, 32'hCAFE0043, 32'hCAFE0043, 0, 0, 0);
		addStep(0, 1, 16'h0053, 32'hBEEF0053, 32'hBEEF0053, 0, 0, 1); // Evicts 0x43
		addStep(0, 0, 16'h0053, 32'h0, 32'hBEEF0053, 1, 0, 0);
		addStep(1, 0, 16'h0043, 32'h0, 32'hCAFE0043, 0, 0, 0);
		addStep(1, 0, 16'h0053, 32'h0, 32'hBEEF0053, 0, 0, 0);
		addStep(0, 1, 16'h0064, 32'h00646464, 32'h00646464, 0, 1, 1);
		addStep(1, 1, 16'h0075, 32'h00757575, 32'h00757575, 0, 0, 1);
		addStep(0, 0, 16'h0075, 32'h0, 32'h00757575, 0, 1, 1);
		addStep(1, 0, 16'h0064, 32'h0, 32'h00646464, 0, 0, 1);
		addStep(0, 0, 16'h0087, 32'h0, 32'h0, 0, 1, 1);
		addStep(1, 0, 16'h0087, 32'h0, 32'h0, 0, 0, 1);

		waitCnt = 0;
		while (rstN !== 1'b1) begin
			waitCnt++;
			if (waitCnt > timeoutCycles)
				abortRun("Reset was never released");
			@(posedge clock);
		end
		@(posedge clock);
		#1;

		i = 0;
		while (i < steps.size()) begin
			holdA = steps[i].backPressure ? pickHold() : 0;
			if (steps[i].parallel && i + 1 < steps.size()) begin
				holdB = steps[i + 1].backPressure ? pickHold() : 0;
				fork
					runStep(i, holdA);
					runStep(i + 1, holdB);
				join
				i += 2;
			end else begin
				runStep(i, holdA);
				i++;
			end
		end

		@(negedge clock);
		if (propFailures != 0) begin
			abortRun("A bound assertion on the bus or a cache failed");
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

/* mesiSystem.f */
src/mesiPkg.sv
src/busArbiter.sv
src/mainMemory.sv
src/snoopBus.sv
src/mesiCacheController.sv
src/mesiCacheSystem.sv
tests/clockGen.sv
tests/mesiSystem_props.sv
tests/mesiSystem_tb.sv

/* Bender.yml */
package:
  name: mesiSystem

sources:
  - files:
      - src/mesiPkg.sv
      - src/busArbiter.sv
      - src/mainMemory.sv
      - src/snoopBus.sv
      - src/mesiCacheController.sv
      - src/mesiCacheSystem.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/mesiSystem_props.sv
      - tests/mesiSystem_tb.sv
